/* logic/scaler_defs.svh */
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

// Stream sample width
`define SAMPLE_W 16

// Gain multiplier width
`define GAIN_W 8

// Right-shift amount, 0 to 7
`define SHIFT_W 3

// Register file address space
`define CFG_ADDR_W 2

// Register map
`define REG_GAIN  0
`define REG_SHIFT 1
`define REG_COUNT 2

`endif

/* logic/scaler_pkg.sv */
`include "scaler_defs.svh"

package scaler_pkg;

    // One unsigned stream sample
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // Gain and shift as held in the register block
    typedef logic [`GAIN_W-1:0] gain_t;
    typedef logic [`SHIFT_W-1:0] shift_t;

    // Full-width product of sample and gain, no bits lost
    typedef logic [`SAMPLE_W+`GAIN_W-1:0] product_t;

    // Register strobe address
    typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;

    // Register data is as wide as a sample, so the counter fits
    typedef logic [`SAMPLE_W-1:0] cfg_data_t;

endpackage

/* logic/skid_buffer.sv */
`timescale 1ns/100ps

module skid_buffer #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_n,

    // Upstream side
    input  logic              s_valid,
    output logic              s_ready,
    input  logic [DATA_W-1:0] s_data,

    // Downstream side
    output logic              m_valid,
    input  logic              m_ready,
    output logic [DATA_W-1:0] m_data
);

    // Main slot drives the outputs, skid slot catches the overflow word
    logic              main_valid;
    logic [DATA_W-1:0] main_data;
    logic              skid_valid;
    logic [DATA_W-1:0] skid_data;
    logic              push;
    logic              pop;

    assign push = s_valid && s_ready;
    assign pop  = main_valid && m_ready;

    // Room for a word unless the skid slot is taken and nothing leaves
    assign s_ready = !skid_valid || pop;

    assign m_valid = main_valid;
    assign m_data  = main_data;

    // Occupancy flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            // Main slot stays full while skid or input can refill it
            if (pop) begin
                main_valid <= skid_valid || push;
            end else if (push) begin
                main_valid <= 1'b1;
            end
            // Skid fills when main is held, empties when it drains into main
            if (push && main_valid && !pop) begin
                skid_valid <= 1'b1;
            end else if (pop && skid_valid) begin
                skid_valid <= push;
            end
        end
    end

    // Payload slots
    always_ff @(posedge clk) begin
        if (pop) begin
            // Skid word is older, so it goes out next
            if (skid_valid) begin
                main_data <= skid_data;
            end else if (push) begin
                main_data <= s_data;
            end
        end else if (push && !main_valid) begin
            main_data <= s_data;
        end
        // Skid takes the new word on a stall, or refills behind a drain
        if (push && main_valid && (!pop || skid_valid)) begin
            skid_data <= s_data;
        end
    end

endmodule

/* logic/gain_stage.sv */
`timescale 1ns/100ps
`include "scaler_defs.svh"

module gain_stage import scaler_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    // Sample input
    input  logic    s_valid,
    output logic    s_ready,
    input  sample_t s_data,

    // Scaled output
    output logic    m_valid,
    input  logic    m_ready,
    output sample_t m_data,

    // Settings from the register block
    input  gain_t   gain,
    input  shift_t  shift
);

    // Stage 1 holds the raw product and the shift that came with it
    logic     s1_valid;
    product_t s1_prod;
    shift_t   s1_shift;

    // Stage 2 holds the final saturated sample
    logic     s2_valid;
    sample_t  s2_data;

    // Advance enables
    logic     s1_adv;
    logic     s2_adv;

    // Shift and clamp between the stages
    product_t shifted;
    sample_t  sat_data;

    // Stage 2 moves when empty or the sink takes its word
    assign s2_adv = !s2_valid || m_ready;

    // Stage 1 moves when empty or stage 2 moves, so bubbles fill up
    assign s1_adv = !s1_valid || s2_adv;

    assign s_ready = s1_adv;

    // Stage valids
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid <= s_valid;
            end
            if (s2_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

    // Stage 1 multiply, full 24-bit product
    always_ff @(posedge clk) begin
        if (s_valid && s1_adv) begin
            s1_prod  <= product_t'(s_data) * product_t'(gain);
            s1_shift <= shift;
        end
    end

    assign shifted = s1_prod >> s1_shift;

    // Anything left above bit 15 clamps to all ones
    assign sat_data = (|shifted[`SAMPLE_W+`GAIN_W-1:`SAMPLE_W]) ? '1
                                                                : shifted[`SAMPLE_W-1:0];

    // Stage 2 register
    always_ff @(posedge clk) begin
        if (s1_valid && s2_adv) begin
            s2_data <= sat_data;
        end
    end

    assign m_valid = s2_valid;
    assign m_data  = s2_data;

endmodule

/* logic/scaler_regs.sv */
`timescale 1ns/100ps
`include "scaler_defs.svh"

module scaler_regs import scaler_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Register strobes
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata,

    // Output handshake, watched for the delivery count
    input  logic      m_valid,
    input  logic      m_ready,

    // Settings to the scaler
    output gain_t     gain,
    output shift_t    shift
);

    // Samples delivered, wraps at 16 bits
    cfg_data_t count;

    // Write decode
    logic wr_gain;
    logic wr_shift;
    logic wr_count;

    assign wr_gain  = cfg_we && (cfg_addr == cfg_addr_t'(`REG_GAIN));
    assign wr_shift = cfg_we && (cfg_addr == cfg_addr_t'(`REG_SHIFT));
    assign wr_count = cfg_we && (cfg_addr == cfg_addr_t'(`REG_COUNT));

    // Gain and shift, unity gain out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gain  <= gain_t'(1);
            shift <= '0;
        end else begin
            // Only the low field bits are kept
            if (wr_gain) begin
                gain <= cfg_wdata[`GAIN_W-1:0];
            end
            if (wr_shift) begin
                shift <= cfg_wdata[`SHIFT_W-1:0];
            end
        end
    end

    // Delivery counter, a write to its address clears it and wins over a transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_count) begin
            count <= '0;
        end else if (m_valid && m_ready) begin
            count <= count + 1'b1;
        end
    end

    // Read mux, fields zero-extended
    always_comb begin
        case (cfg_addr)
            cfg_addr_t'(`REG_GAIN):  cfg_rdata = cfg_data_t'(gain);
            cfg_addr_t'(`REG_SHIFT): cfg_rdata = cfg_data_t'(shift);
            cfg_addr_t'(`REG_COUNT): cfg_rdata = count;
            default:                 cfg_rdata = '0;
        endcase
    end

endmodule

/* logic/scaler_top.sv */
`timescale 1ns/100ps
`include "scaler_defs.svh"

module scaler_top import scaler_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Sample stream in
    input  logic      s_valid,
    output logic      s_ready,
    input  sample_t   s_data,

    // Scaled stream out
    output logic      m_valid,
    input  logic      m_ready,
    output sample_t   m_data,

    // Register strobes
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata
);

    // Input buffer to scaler
    logic    in_valid;
    logic    in_ready;
    sample_t in_data;

    // Scaler to output buffer
    logic    sc_valid;
    logic    sc_ready;
    sample_t sc_data;

    // Current settings
    gain_t   gain;
    shift_t  shift;

    // Decouples the upstream source
    skid_buffer #(
        .DATA_W  (`SAMPLE_W)
    ) in_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (in_valid),
        .m_ready (in_ready),
        .m_data  (in_data)
    );

    // Multiply, shift, saturate
    gain_stage gain_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (in_data),
        .m_valid (sc_valid),
        .m_ready (sc_ready),
        .m_data  (sc_data),
        .gain    (gain),
        .shift   (shift)
    );

    // Registers the result toward the sink
    skid_buffer #(
        .DATA_W  (`SAMPLE_W)
    ) out_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (sc_valid),
        .s_ready (sc_ready),
        .s_data  (sc_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data)
    );

    // Counts transfers on the top output port
    scaler_regs scaler_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .gain      (gain),
        .shift     (shift)
    );

endmodule

/* testbench/scaler_chk.sv */
`timescale 1ns/100ps

module scaler_chk import scaler_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    s_valid,
    input logic    s_ready,
    input sample_t s_data,
    input logic    m_valid,
    input logic    m_ready,
    input sample_t m_data
);

    // Failures so far, looked at by the testbench at the end of the run
    int unsigned fail_count = 0;

    // Stalled upstream word stays put
    s_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_valid && !s_ready |=> s_valid && $stable(s_data))
    else begin
        $error("s_valid or s_data changed while stalled");
        fail_count++;
    end

    // Stalled output word stays put
    m_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
    else begin
        $error("m_valid or m_data changed while stalled");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else begin
        $error("m_valid high during reset");
        fail_count++;
    end

    // First edge out of reset, input buffer is empty
    ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> s_ready)
    else begin
        $error("s_ready low in the cycle after reset");
        fail_count++;
    end

endmodule

bind scaler_top scaler_chk scaler_chk_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
);

/* testbench/scaler_tb.sv */
`timescale 1ns/100ps
`include "scaler_defs.svh"

module scaler_tb import scaler_pkg::*; ;

    // One table row: settings, sample count, ramp start and step, sink mode
    typedef struct packed {
        gain_t       gain;
        shift_t      shift;
        logic [15:0] n_samples;
        sample_t     first;
        sample_t     step;
        logic        full_rate;
    } entry_t;

    localparam int N_ENTRIES = 9;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      s_valid;
    logic      s_ready;
    sample_t   s_data;
    logic      m_valid;
    logic      m_ready;
    sample_t   m_data;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    cfg_data_t cfg_rdata;

    entry_t      tbl [N_ENTRIES];
    logic [31:0] lfsr_state = 32'h1e9ca53f;
    int          cycle = 0;
    int          out_count = 0;
    logic        full_rate;
    string       test_name;

    // Expected samples and the edge each one was accepted at
    sample_t     exp_q [$];
    int          acc_q [$];

    scaler_top scaler_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_data    (s_data),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return bits;
    endfunction

    // Sample times gain, shifted right, clamped to 16 bits
    function automatic sample_t scale_ref(input sample_t d, input gain_t g, input shift_t sh);
        logic [31:0] prod;
        prod = (32'(d) * 32'(g)) >> sh;
        if (prod > 32'h0000_ffff) begin
            return 16'hffff;
        end else begin
            return prod[15:0];
        end
    endfunction

    task automatic load_table();
        // gain, shift, samples, first, step, sink always ready
        tbl[0] = '{8'h01, 3'd0, 16'd12, 16'h0010, 16'h1111, 1'b1};
        tbl[1] = '{8'h03, 3'd2, 16'd16, 16'h0100, 16'h0733, 1'b1};
        tbl[2] = '{8'h00, 3'd3, 16'd8,  16'hffff, 16'h0101, 1'b0};
        tbl[3] = '{8'hff, 3'd7, 16'd20, 16'h0000, 16'h0ccd, 1'b0};
        tbl[4] = '{8'h80, 3'd0, 16'd20, 16'h0000, 16'h0101, 1'b0};
        tbl[5] = '{8'hff, 3'd1, 16'd24, 16'h00f0, 16'h0040, 1'b0};
        tbl[6] = '{8'h5a, 3'd5, 16'd64, 16'h1234, 16'h3c3b, 1'b0};
        tbl[7] = '{8'hc3, 3'd6, 16'd32, 16'hffff, 16'hfff1, 1'b1};
        tbl[8] = '{8'h02, 3'd4, 16'd40, 16'h8000, 16'h0a3d, 1'b0};
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge clk);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    // Read data is taken just before the edge, where it has settled
    task automatic cfg_read(input cfg_addr_t addr, output cfg_data_t data);
        @(negedge clk);
        cfg_addr = addr;
        @(posedge clk);
        data = cfg_rdata;
    endtask

    task automatic send_sample(input sample_t d, input sample_t expected);
        @(negedge clk);
        // Gap cycles, each taken with a chance of one in four
        while (!full_rate && lfsr_bits(2) == 32'd0) begin
            s_valid = 1'b0;
            @(negedge clk);
        end
        s_valid = 1'b1;
        s_data  = d;
        @(posedge clk);
        // Nothing stalls at full rate, so a sample goes in every cycle
        if (full_rate) begin
            check_value($sformatf("%s s_ready at full rate", test_name),
                        32'd1, 32'(s_ready));
        end
        while (!s_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(expected);
        acc_q.push_back(cycle);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic run_entry(input int e);
        entry_t    ent;
        cfg_data_t rd;
        sample_t   smp;
        ent = tbl[e];
        // Pipe is empty, settings may change now
        cfg_write(cfg_addr_t'(`REG_COUNT), 16'hbeef);
        cfg_read(cfg_addr_t'(`REG_COUNT), rd);
        check_value($sformatf("entry %0d count clear", e), 32'd0, 32'(rd));
        // Junk in the upper bits must be dropped
        cfg_write(cfg_addr_t'(`REG_GAIN), {~ent.gain, ent.gain});
        cfg_write(cfg_addr_t'(`REG_SHIFT), {13'h15a3, ent.shift});
        cfg_read(cfg_addr_t'(`REG_GAIN), rd);
        check_value($sformatf("entry %0d gain readback", e), 32'(ent.gain), 32'(rd));
        cfg_read(cfg_addr_t'(`REG_SHIFT), rd);
        check_value($sformatf("entry %0d shift readback", e), 32'(ent.shift), 32'(rd));
        @(negedge clk);
        full_rate = ent.full_rate;
        test_name = $sformatf("entry %0d", e);
        smp = ent.first;
        for (int i = 0; i < int'(ent.n_samples); i++) begin
            send_sample(smp, scale_ref(smp, ent.gain, ent.shift));
            smp = smp + ent.step;
        end
        @(negedge clk);
        s_valid = 1'b0;
        wait_drain();
        cfg_read(cfg_addr_t'(`REG_COUNT), rd);
        check_value($sformatf("entry %0d delivered count", e), 32'(ent.n_samples), 32'(rd));
    endtask

    // Sink side, ready drawn after each edge and applied at the next falling edge
    initial begin : sink
        logic [31:0] r;
        logic        nxt;
        m_ready = 1'b0;
        forever begin
            @(posedge clk);
            r   = lfsr_bits(1);
            nxt = r[0] | full_rate;
            @(negedge clk);
            m_ready = nxt;
        end
    end

    // Every output transfer is checked in order
    always @(posedge clk) begin : monitor
        sample_t expected;
        int      accepted;
        if (rst_n && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("An output word arrived with no sample outstanding");
            end else begin
                expected = exp_q.pop_front();
                accepted = acc_q.pop_front();
                check_value($sformatf("%s out %0d data", test_name, out_count),
                            32'(expected), 32'(m_data));
                // Acceptance at edge N, transfer out at edge N+4
                if (full_rate) begin
                    check_value($sformatf("%s out %0d latency", test_name, out_count),
                                32'd4, 32'(cycle - accepted));
                end
                out_count++;
            end
        end
    end

    initial begin : watchdog
        int total;
        total = 0;
        @(posedge rst_n);
        for (int e = 0; e < N_ENTRIES; e++) begin
            total += int'(tbl[e].n_samples);
        end
        repeat (40 * total + 200) @(posedge clk);
        fail_run($sformatf("Timeout: run did not finish within %0d cycles", 40 * total + 200));
    end

    initial begin : main
        cfg_data_t rd;
        rst_n     = 1'b0;
        s_valid   = 1'b0;
        s_data    = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        full_rate = 1'b1;
        test_name = "reset";
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values and the unused address
        cfg_read(cfg_addr_t'(`REG_GAIN), rd);
        check_value("reset gain", 32'd1, 32'(rd));
        cfg_read(cfg_addr_t'(`REG_SHIFT), rd);
        check_value("reset shift", 32'd0, 32'(rd));
        cfg_read(cfg_addr_t'(`REG_COUNT), rd);
        check_value("reset count", 32'd0, 32'(rd));
        cfg_read(cfg_addr_t'(3), rd);
        check_value("address 3 read", 32'd0, 32'(rd));

        for (int e = 0; e < N_ENTRIES; e++) begin
            run_entry(e);
        end

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_run("Samples were still outstanding at the end of the run");
        end else if (scaler_top_i.scaler_chk_i.fail_count != 0) begin
            fail_run("A handshake assertion failed during the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+logic
logic/scaler_pkg.sv
logic/skid_buffer.sv
logic/gain_stage.sv
logic/scaler_regs.sv
logic/scaler_top.sv
testbench/scaler_chk.sv
testbench/scaler_tb.sv

/* Makefile */
TOP := scaler_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
